// ==== include/synth_macros.svh ====
`ifndef SYNTH_MACROS_SVH
`define SYNTH_MACROS_SVH

// clocks per audio sample tick
`define SAMPLE_DIV 16
// amount one adjust key moves a parameter
`define PARAM_STEP 8'd16

// power-up voice settings
`define DEF_AMPLITUDE 8'd255
`define DEF_ATTACK 8'd255
`define DEF_DECAY 8'd0
`define DEF_SUSTAIN 8'd255
`define DEF_RELEASE 8'd255
`define DEF_OCTAVE 8'd4

// set 2 scan codes, break prefix first
`define SC_BREAK 8'hF0

// bottom keyboard row plus sharps, notes 0 to 11
`define SC_NOTE_0 8'h1A
`define SC_NOTE_1 8'h1B
`define SC_NOTE_2 8'h22
`define SC_NOTE_3 8'h23
`define SC_NOTE_4 8'h21
`define SC_NOTE_5 8'h2A
`define SC_NOTE_6 8'h34
`define SC_NOTE_7 8'h32
`define SC_NOTE_8 8'h33
`define SC_NOTE_9 8'h31
`define SC_NOTE_10 8'h3B
`define SC_NOTE_11 8'h3A

// minus and equals
`define SC_OCT_DOWN 8'h4E
`define SC_OCT_UP 8'h55

// digit keys 1 to 5
`define SC_SEL_1 8'h16
`define SC_SEL_2 8'h1E
`define SC_SEL_3 8'h26
`define SC_SEL_4 8'h25
`define SC_SEL_5 8'h2E

// square brackets
`define SC_ADJ_DOWN 8'h54
`define SC_ADJ_UP 8'h5B

`endif

// ==== project.f ====
+incdir+include
src/synth_pkg.sv
src/ps2_receiver.sv
src/key_mapper.sv
src/param_store.sv
src/voice_engine.sv
src/synth_top.sv
test/synth_checker.sv
test/synth_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the synthesizer testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f project.f --top-module synth_tb -o synth_sim

# the simulator exit status is the result of the run
./obj_dir/synth_sim

// ==== src/key_mapper.sv ====
`timescale 1ns/100ps
`include "synth_macros.svh"

module key_mapper import synth_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [7:0]  code,
    input  logic        code_valid,
    output logic [3:0]  note,
    output logic        note_active,
    output param_addr_t param_sel,
    output logic        req,
    output store_op_t   op,
    output param_addr_t addr,
    input  logic        ack
);

    map_state_t  state;
    // next code is a key release
    logic        brk;
    logic        key_hit;
    logic [3:0]  key_note;
    logic        cmd_hit;
    store_op_t   cmd_op;
    param_addr_t cmd_addr;

    // note key lookup
    always_comb begin
        key_hit = 1'b1;
        case (code)
            `SC_NOTE_0:  key_note = 4'd0;
            `SC_NOTE_1:  key_note = 4'd1;
            `SC_NOTE_2:  key_note = 4'd2;
            `SC_NOTE_3:  key_note = 4'd3;
            `SC_NOTE_4:  key_note = 4'd4;
            `SC_NOTE_5:  key_note = 4'd5;
            `SC_NOTE_6:  key_note = 4'd6;
            `SC_NOTE_7:  key_note = 4'd7;
            `SC_NOTE_8:  key_note = 4'd8;
            `SC_NOTE_9:  key_note = 4'd9;
            `SC_NOTE_10: key_note = 4'd10;
            `SC_NOTE_11: key_note = 4'd11;
            default: begin
                key_hit  = 1'b0;
                key_note = 4'd0;
            end
        endcase
    end

    // keys that turn into a store command
    always_comb begin
        cmd_hit  = 1'b1;
        cmd_op   = OP_READ;
        cmd_addr = param_sel;
        case (code)
            `SC_ADJ_UP:   cmd_op = OP_INC;
            `SC_ADJ_DOWN: cmd_op = OP_DEC;
            `SC_OCT_UP: begin
                cmd_op   = OP_OCT_INC;
                cmd_addr = PAR_OCTAVE;
            end
            `SC_OCT_DOWN: begin
                cmd_op   = OP_OCT_DEC;
                cmd_addr = PAR_OCTAVE;
            end
            default: cmd_hit = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            state       <= MAP_IDLE;
            brk         <= 1'b0;
            note        <= 4'd0;
            note_active <= 1'b0;
            param_sel   <= PAR_AMPLITUDE;
            req         <= 1'b0;
        end else begin
            case (state)
                MAP_REQ: begin
                    if (ack) begin
                        req   <= 1'b0;
                        state <= MAP_WAIT_DROP;
                    end
                end
                // wait for the store to release ack
                MAP_WAIT_DROP: if (!ack) state <= MAP_IDLE;
                default: ;
            endcase
            if (code_valid) begin
                if (code == `SC_BREAK) begin
                    brk <= 1'b1;
                end else if (brk) begin
                    brk <= 1'b0;
                    // only the held note ends, other releases ignored
                    if (key_hit && key_note == note) note_active <= 1'b0;
                end else if (key_hit) begin
                    note        <= key_note;
                    note_active <= 1'b1;
                end else if (code == `SC_SEL_1) begin
                    param_sel <= PAR_AMPLITUDE;
                end else if (code == `SC_SEL_2) begin
                    param_sel <= PAR_ATTACK;
                end else if (code == `SC_SEL_3) begin
                    param_sel <= PAR_DECAY;
                end else if (code == `SC_SEL_4) begin
                    param_sel <= PAR_SUSTAIN;
                end else if (code == `SC_SEL_5) begin
                    param_sel <= PAR_RELEASE;
                end else if (cmd_hit && state == MAP_IDLE) begin
                    req   <= 1'b1;
                    state <= MAP_REQ;
                end
            end
        end
    end

    // command payload, held while req is up
    always_ff @(posedge clk) begin
        if (code_valid && !brk && cmd_hit && state == MAP_IDLE) begin
            op   <= cmd_op;
            addr <= cmd_addr;
        end
    end

endmodule

// ==== src/param_store.sv ====
`timescale 1ns/100ps
`include "synth_macros.svh"

module param_store import synth_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        m_req,
    input  store_op_t   m_op,
    input  param_addr_t m_addr,
    output logic        m_ack,
    input  logic        v_req,
    input  store_op_t   v_op,
    input  param_addr_t v_addr,
    output logic        v_ack,
    output logic [7:0]  v_rdata,
    input  param_addr_t param_sel,
    output logic [2:0]  octave,
    output logic [7:0]  param_level
);

    logic [7:0]  par_q [6];
    // voice got the last grant
    logic        last_v;
    logic        m_pend;
    logic        v_pend;
    logic        grant_m;
    logic        grant_v;
    store_op_t   sel_op;
    param_addr_t sel_addr;
    logic [7:0]  cur;
    logic [7:0]  nxt;

    // a port with ack still up is already served
    assign m_pend  = m_req & ~m_ack;
    assign v_pend  = v_req & ~v_ack;
    // round robin on collision
    assign grant_m = m_pend & (~v_pend | last_v);
    assign grant_v = v_pend & ~grant_m;

    assign sel_op   = grant_m ? m_op : v_op;
    assign sel_addr = grant_m ? m_addr : v_addr;
    assign cur      = par_q[sel_addr];

    // saturating update
    always_comb begin
        case (sel_op)
            OP_INC:     nxt = (cur > 8'd255 - `PARAM_STEP) ? 8'd255 : cur + `PARAM_STEP;
            OP_DEC:     nxt = (cur < `PARAM_STEP) ? 8'd0 : cur - `PARAM_STEP;
            OP_OCT_INC: nxt = (cur >= 8'd7) ? 8'd7 : cur + 8'd1;
            OP_OCT_DEC: nxt = (cur == 8'd0) ? 8'd0 : cur - 8'd1;
            default:    nxt = cur;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            par_q[PAR_AMPLITUDE] <= `DEF_AMPLITUDE;
            par_q[PAR_ATTACK]    <= `DEF_ATTACK;
            par_q[PAR_DECAY]     <= `DEF_DECAY;
            par_q[PAR_SUSTAIN]   <= `DEF_SUSTAIN;
            par_q[PAR_RELEASE]   <= `DEF_RELEASE;
            par_q[PAR_OCTAVE]    <= `DEF_OCTAVE;
            last_v               <= 1'b0;
            m_ack                <= 1'b0;
            v_ack                <= 1'b0;
        end else begin
            if ((grant_m || grant_v) && sel_addr <= PAR_OCTAVE) begin
                par_q[sel_addr] <= nxt;
                last_v          <= grant_v;
            end
            // ack one cycle after accept, cleared once req drops
            if (grant_m) m_ack <= 1'b1;
            else if (!m_req) m_ack <= 1'b0;
            if (grant_v) v_ack <= 1'b1;
            else if (!v_req) v_ack <= 1'b0;
        end
    end

    // read result rides with v_ack
    always_ff @(posedge clk) begin
        if (grant_v) v_rdata <= nxt;
    end

    assign octave      = par_q[PAR_OCTAVE][2:0];
    assign param_level = par_q[param_sel];

endmodule

// ==== src/ps2_receiver.sv ====
`timescale 1ns/100ps

module ps2_receiver (
    input  logic       clk,
    input  logic       reset,
    input  logic       ps2_clk,
    input  logic       ps2_dat,
    output logic [7:0] code,
    output logic       code_valid,
    output logic       frame_error
);

    // two-flop synchronizers, lines idle high
    logic [1:0] clk_sync;
    logic [1:0] dat_sync;
    logic       clk_prev;
    logic       fall;
    // bit position inside the 11-bit frame
    logic [3:0] bit_cnt;
    // start, data lsb first, parity
    logic [9:0] shift;
    logic       frame_ok;

    assign fall = clk_prev & ~clk_sync[1];

    // stop bit is the live data line on the 11th edge
    // odd parity over data and parity bit
    assign frame_ok = ~shift[0] & (^shift[9:1]) & dat_sync[1];

    always_ff @(posedge clk) begin
        if (!reset) begin
            clk_sync    <= 2'b11;
            dat_sync    <= 2'b11;
            clk_prev    <= 1'b1;
            bit_cnt     <= 4'd0;
            code_valid  <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            clk_sync    <= {clk_sync[0], ps2_clk};
            dat_sync    <= {dat_sync[0], ps2_dat};
            clk_prev    <= clk_sync[1];
            code_valid  <= 1'b0;
            frame_error <= 1'b0;
            if (fall) begin
                if (bit_cnt == 4'd10) begin
                    bit_cnt     <= 4'd0;
                    code_valid  <= frame_ok;
                    frame_error <= ~frame_ok;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
        end
    end

    // frame payload, only meaningful with code_valid
    always_ff @(posedge clk) begin
        if (fall && bit_cnt != 4'd10) begin
            shift <= {dat_sync[1], shift[9:1]};
        end
        if (fall && bit_cnt == 4'd10) begin
            code <= shift[8:1];
        end
    end

endmodule

// ==== src/synth_pkg.sv ====
package synth_pkg;

    // operations the parameter store understands
    typedef enum logic [2:0] {
        OP_READ,
        OP_INC,
        OP_DEC,
        OP_OCT_INC,
        OP_OCT_DEC
    } store_op_t;

    // register index inside the store, octave last
    typedef enum logic [2:0] {
        PAR_AMPLITUDE,
        PAR_ATTACK,
        PAR_DECAY,
        PAR_SUSTAIN,
        PAR_RELEASE,
        PAR_OCTAVE
    } param_addr_t;

    // ADSR phases of the voice
    typedef enum logic [2:0] {
        ENV_IDLE,
        ENV_ATTACK,
        ENV_DECAY,
        ENV_SUSTAIN,
        ENV_RELEASE
    } env_state_t;

    // mapper store handshake
    typedef enum logic [1:0] {
        MAP_IDLE,
        MAP_REQ,
        MAP_WAIT_DROP
    } map_state_t;

endpackage

// ==== src/synth_top.sv ====
`timescale 1ns/100ps

module synth_top import synth_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               ps2_clk,
    input  logic               ps2_dat,
    output logic [2:0]         octave,
    output param_addr_t        param_sel,
    output logic [7:0]         param_level,
    output logic [3:0]         note,
    output logic               note_active,
    output logic signed [15:0] sample,
    output logic               sample_valid,
    output logic               frame_error
);

    logic [7:0]  code;
    logic        code_valid;
    // mapper store port
    logic        m_req;
    store_op_t   m_op;
    param_addr_t m_addr;
    logic        m_ack;
    // voice store port
    logic        v_req;
    store_op_t   v_op;
    param_addr_t v_addr;
    logic        v_ack;
    logic [7:0]  v_rdata;

    ps2_receiver rx_i (
        .clk         (clk),
        .reset       (reset),
        .ps2_clk     (ps2_clk),
        .ps2_dat     (ps2_dat),
        .code        (code),
        .code_valid  (code_valid),
        .frame_error (frame_error)
    );

    key_mapper map_i (
        .clk         (clk),
        .reset       (reset),
        .code        (code),
        .code_valid  (code_valid),
        .note        (note),
        .note_active (note_active),
        .param_sel   (param_sel),
        .req         (m_req),
        .op          (m_op),
        .addr        (m_addr),
        .ack         (m_ack)
    );

    param_store store_i (
        .clk         (clk),
        .reset       (reset),
        .m_req       (m_req),
        .m_op        (m_op),
        .m_addr      (m_addr),
        .m_ack       (m_ack),
        .v_req       (v_req),
        .v_op        (v_op),
        .v_addr      (v_addr),
        .v_ack       (v_ack),
        .v_rdata     (v_rdata),
        .param_sel   (param_sel),
        .octave      (octave),
        .param_level (param_level)
    );

    voice_engine voice_i (
        .clk          (clk),
        .reset        (reset),
        .note         (note),
        .note_active  (note_active),
        .req          (v_req),
        .op           (v_op),
        .addr         (v_addr),
        .ack          (v_ack),
        .rdata        (v_rdata),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

endmodule

// ==== src/voice_engine.sv ====
`timescale 1ns/100ps
`include "synth_macros.svh"

module voice_engine import synth_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic [3:0]         note,
    input  logic               note_active,
    output logic               req,
    output store_op_t          op,
    output param_addr_t        addr,
    input  logic               ack,
    input  logic [7:0]         rdata,
    output logic signed [15:0] sample,
    output logic               sample_valid
);

    logic [3:0]  tick_cnt;
    logic        tick;
    // local copy of the store, refreshed one entry per tick
    logic [7:0]  cache [6];
    param_addr_t rd_idx;
    logic [15:0] phase;
    logic [15:0] inc;
    env_state_t  state;
    env_state_t  state_n;
    logic [7:0]  env;
    logic [7:0]  env_n;
    logic [8:0]  att_sum;
    logic [15:0] level;
    logic [14:0] mag;

    // octave-0 phase steps, roughly a semitone apart
    function automatic logic [15:0] base_inc(input logic [3:0] n);
        case (n)
            4'd0:    base_inc = 16'd64;
            4'd1:    base_inc = 16'd68;
            4'd2:    base_inc = 16'd72;
            4'd3:    base_inc = 16'd76;
            4'd4:    base_inc = 16'd81;
            4'd5:    base_inc = 16'd86;
            4'd6:    base_inc = 16'd91;
            4'd7:    base_inc = 16'd96;
            4'd8:    base_inc = 16'd102;
            4'd9:    base_inc = 16'd108;
            4'd10:   base_inc = 16'd114;
            4'd11:   base_inc = 16'd121;
            default: base_inc = 16'd0;
        endcase
    endfunction

    assign tick    = tick_cnt == 4'(`SAMPLE_DIV - 1);
    assign op      = OP_READ;
    // rd_idx only moves after ack, so addr is stable under req
    assign addr    = rd_idx;
    assign inc     = base_inc(note) << cache[PAR_OCTAVE][2:0];
    assign att_sum = {1'b0, env} + {1'b0, cache[PAR_ATTACK]} + 9'd1;
    // envelope times amplitude, halved
    assign level   = env_n * cache[PAR_AMPLITUDE];
    assign mag     = level[15:1];

    // envelope step applied on the next tick
    always_comb begin
        state_n = state;
        env_n   = env;
        if (note_active && state != ENV_DECAY && state != ENV_SUSTAIN) begin
            // retrigger from idle or release
            if (att_sum >= 9'd255) begin
                env_n   = 8'd255;
                state_n = ENV_DECAY;
            end else begin
                env_n   = att_sum[7:0];
                state_n = ENV_ATTACK;
            end
        end else if (note_active && state == ENV_DECAY) begin
            if ({1'b0, env} <= {1'b0, cache[PAR_SUSTAIN]} + {1'b0, cache[PAR_DECAY]}) begin
                env_n   = cache[PAR_SUSTAIN];
                state_n = ENV_SUSTAIN;
            end else begin
                env_n = env - cache[PAR_DECAY];
            end
        end else if (note_active) begin
            env_n = cache[PAR_SUSTAIN];
        end else if (state != ENV_IDLE) begin
            if (env <= cache[PAR_RELEASE]) begin
                env_n   = 8'd0;
                state_n = ENV_IDLE;
            end else begin
                env_n   = env - cache[PAR_RELEASE] - 8'd1;
                state_n = ENV_RELEASE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            tick_cnt             <= 4'd0;
            sample_valid         <= 1'b0;
            sample               <= 16'sd0;
            phase                <= 16'd0;
            state                <= ENV_IDLE;
            env                  <= 8'd0;
            req                  <= 1'b0;
            rd_idx               <= PAR_AMPLITUDE;
            cache[PAR_AMPLITUDE] <= `DEF_AMPLITUDE;
            cache[PAR_ATTACK]    <= `DEF_ATTACK;
            cache[PAR_DECAY]     <= `DEF_DECAY;
            cache[PAR_SUSTAIN]   <= `DEF_SUSTAIN;
            cache[PAR_RELEASE]   <= `DEF_RELEASE;
            cache[PAR_OCTAVE]    <= `DEF_OCTAVE;
        end else begin
            tick_cnt     <= tick ? 4'd0 : tick_cnt + 4'd1;
            sample_valid <= tick;
            if (tick) begin
                phase <= phase + inc;
                state <= state_n;
                env   <= env_n;
                // square sign from phase msb, silent when idle
                if (state_n == ENV_IDLE) sample <= 16'sd0;
                else if (phase[15]) sample <= -$signed({1'b0, mag});
                else sample <= $signed({1'b0, mag});
            end
            // refresh read, skipped while a previous one is in flight
            if (req && ack) begin
                cache[rd_idx] <= rdata;
                req           <= 1'b0;
                if (rd_idx == PAR_OCTAVE) rd_idx <= PAR_AMPLITUDE;
                else rd_idx <= param_addr_t'(rd_idx + 3'd1);
            end else if (tick && !req && !ack) begin
                req <= 1'b1;
            end
        end
    end

endmodule

// ==== test/synth_checker.sv ====
`timescale 1ns/100ps

module synth_checker import synth_pkg::*; (
    input logic               clk,
    input logic               reset,
    input logic               m_req,
    input store_op_t          m_op,
    input param_addr_t        m_addr,
    input logic               m_ack,
    input logic               v_req,
    input param_addr_t        v_addr,
    input logic               v_ack,
    input logic signed [15:0] sample,
    input logic               sample_valid,
    input logic               note_active,
    input logic               frame_error
);

    // values seen on the first edge out of reset
    reset_values_a: assert property (@(posedge clk)
        $rose(reset) |-> (!m_req && !m_ack && !v_req && !v_ack && !sample_valid
                          && !frame_error && !note_active && sample == 16'sd0))
        else $error("outputs not at reset values after reset release");

    // request and payload held until the store answers
    m_hold_a: assert property (@(posedge clk) disable iff (!reset)
        m_req && !m_ack |=> m_req && $stable(m_op) && $stable(m_addr))
        else $error("mapper request changed before ack");
    v_hold_a: assert property (@(posedge clk) disable iff (!reset)
        v_req && !v_ack |=> v_req && $stable(v_addr))
        else $error("voice request changed before ack");

    // ack only answers a live request
    m_ack_req_a: assert property (@(posedge clk) disable iff (!reset)
        $rose(m_ack) |-> m_req)
        else $error("mapper ack rose without a request");
    v_ack_req_a: assert property (@(posedge clk) disable iff (!reset)
        $rose(v_ack) |-> v_req)
        else $error("voice ack rose without a request");

    // ack falls the cycle after req falls
    m_ack_drop_a: assert property (@(posedge clk) disable iff (!reset)
        m_ack && !m_req |=> !m_ack)
        else $error("mapper ack held after request dropped");
    v_ack_drop_a: assert property (@(posedge clk) disable iff (!reset)
        v_ack && !v_req |=> !v_ack)
        else $error("voice ack held after request dropped");

    // four-phase: no new request over a high ack
    m_new_req_a: assert property (@(posedge clk) disable iff (!reset)
        $rose(m_req) |-> !m_ack)
        else $error("mapper raised a request while ack was high");
    v_new_req_a: assert property (@(posedge clk) disable iff (!reset)
        $rose(v_req) |-> !v_ack)
        else $error("voice raised a request while ack was high");

    // sample only moves together with its strobe
    sample_strobe_a: assert property (@(posedge clk) disable iff (!reset)
        !$stable(sample) |-> sample_valid)
        else $error("sample changed without sample_valid");

    // one-cycle strobe, 16 clocks apart
    valid_pulse_a: assert property (@(posedge clk) disable iff (!reset)
        sample_valid |=> !sample_valid)
        else $error("sample_valid longer than one cycle");
    valid_period_a: assert property (@(posedge clk) disable iff (!reset)
        sample_valid && $past(reset, 17) |-> $past(sample_valid, 16))
        else $error("sample_valid not 16 clocks after the previous pulse");

endmodule

// ==== test/synth_tb.sv ====
`timescale 1ns/100ps
`include "synth_macros.svh"

module synth_tb import synth_pkg::*; ();

    // system clocks per PS/2 half period
    localparam int PS2_HALF       = 8;
    // 60 frames of about 250 clocks each
    localparam int TIMEOUT_CYCLES = 60 * 250;
    localparam int STEP           = 16;
    // 255 * 255 / 2
    localparam int FULL_MAG       = 32512;

    logic               clk;
    logic               reset;
    // keyboard side pulls the lines low, a pull-up holds them high
    logic               clk_pull;
    logic               dat_pull;
    wire                ps2_clk;
    wire                ps2_dat;
    logic [2:0]         octave;
    param_addr_t        param_sel;
    logic [7:0]         param_level;
    logic [3:0]         note;
    logic               note_active;
    logic signed [15:0] sample;
    logic               sample_valid;
    logic               frame_error;

    // reference model, index 0 to 4 is amplitude to release
    int                 model_par [5];
    int                 model_oct;
    int                 model_sel;
    logic [15:0]        lfsr;
    int                 cycles = 0;
    int                 fe_count = 0;

    assign ps2_clk = ~clk_pull;
    assign ps2_dat = ~dat_pull;

    synth_top dut_i (
        .clk          (clk),
        .reset        (reset),
        .ps2_clk      (ps2_clk),
        .ps2_dat      (ps2_dat),
        .octave       (octave),
        .param_sel    (param_sel),
        .param_level  (param_level),
        .note         (note),
        .note_active  (note_active),
        .sample       (sample),
        .sample_valid (sample_valid),
        .frame_error  (frame_error)
    );

    bind synth_top synth_checker chk_i (
        .clk          (clk),
        .reset        (reset),
        .m_req        (m_req),
        .m_op         (m_op),
        .m_addr       (m_addr),
        .m_ack        (m_ack),
        .v_req        (v_req),
        .v_addr       (v_addr),
        .v_ack        (v_ack),
        .sample       (sample),
        .sample_valid (sample_valid),
        .note_active  (note_active),
        .frame_error  (frame_error)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) fail_now("timeout, run exceeded its cycle limit");
    end

    // count error pulses where they are stable
    always @(negedge clk) begin
        if (frame_error) fe_count++;
    end

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input int got, input int exp);
        assert (got == exp)
        else fail_now($sformatf("mismatch at %0d ns: %s is %0d, expected %0d",
                                $time, name, got, exp));
    endtask

    // saturating step of one voice parameter
    function automatic int sat_param(input int v, input bit up);
        if (up) sat_param = (v + STEP > 255) ? 255 : v + STEP;
        else sat_param = (v < STEP) ? 0 : v - STEP;
    endfunction

    function automatic int sat_octave(input int v, input bit up);
        if (up) sat_octave = (v >= 7) ? 7 : v + 1;
        else sat_octave = (v <= 0) ? 0 : v - 1;
    endfunction

    function automatic int magnitude(input logic signed [15:0] s);
        magnitude = (s < 0) ? -int'(s) : int'(s);
    endfunction

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output int val);
        int k;
        val = 0;
        for (k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            val  = (val << 1) | int'(lfsr[0]);
        end
    endtask

    function automatic logic [7:0] sel_code(input int idx);
        case (idx)
            0:       sel_code = `SC_SEL_1;
            1:       sel_code = `SC_SEL_2;
            2:       sel_code = `SC_SEL_3;
            3:       sel_code = `SC_SEL_4;
            default: sel_code = `SC_SEL_5;
        endcase
    endfunction

    // start, data lsb first, odd parity, stop
    task automatic send_frame(input logic [7:0] data, input bit bad_parity);
        logic [10:0] bits;
        logic        par;
        int          i;
        par  = ~(^data) ^ bad_parity;
        bits = {1'b1, par, data, 1'b0};
        for (i = 0; i < 11; i++) begin
            dat_pull = ~bits[i];
            repeat (PS2_HALF) @(negedge clk);
            // device samples on the falling clock
            clk_pull = 1'b1;
            repeat (PS2_HALF) @(negedge clk);
            clk_pull = 1'b0;
        end
        dat_pull = 1'b0;
        repeat (PS2_HALF) @(negedge clk);
    endtask

    // store command ends when the mapper is back in idle
    task automatic wait_mapper_idle();
        int n;
        n = 0;
        while (dut_i.map_i.state != MAP_IDLE && n < 16) begin
            @(negedge clk);
            n++;
        end
        assert (dut_i.map_i.state == MAP_IDLE)
        else fail_now("store command from the key mapper did not complete");
    endtask

    task automatic wait_tick();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!sample_valid && n < 2 * `SAMPLE_DIV);
        assert (sample_valid) else fail_now("no sample_valid pulse within two sample periods");
    endtask

    task automatic check_params();
        check_value("octave", int'(octave), model_oct);
        check_value("param_sel", int'(param_sel), model_sel);
        check_value("param_level", int'(param_level), model_par[model_sel]);
    endtask

    task automatic press_octave(input bit up);
        send_frame(up ? `SC_OCT_UP : `SC_OCT_DOWN, 1'b0);
        model_oct = sat_octave(model_oct, up);
        wait_mapper_idle();
        check_params();
    endtask

    // 0 to 4 select, 5 minus, 6 and 7 plus
    task automatic press_random_key();
        int pick;
        draw_bits(3, pick);
        if (pick < 5) begin
            send_frame(sel_code(pick), 1'b0);
            model_sel = pick;
        end else if (pick == 5) begin
            send_frame(`SC_ADJ_DOWN, 1'b0);
            model_par[model_sel] = sat_param(model_par[model_sel], 1'b0);
        end else begin
            send_frame(`SC_ADJ_UP, 1'b0);
            model_par[model_sel] = sat_param(model_par[model_sel], 1'b1);
        end
        wait_mapper_idle();
        check_params();
    endtask

    initial begin
        int i;
        int fe_before;
        bit ok;
        bit neg0;
        bit flipped;
        reset     = 1'b0;
        clk_pull  = 1'b0;
        dat_pull  = 1'b0;
        lfsr      = 16'd65308;
        model_par = '{255, 255, 0, 255, 255};
        model_oct = 4;
        model_sel = 0;
        repeat (8) @(negedge clk);
        reset = 1'b1;
        @(negedge clk);

        // defaults out of reset
        check_params();
        check_value("sample", int'(sample), 0);
        check_value("note_active", int'(note_active), 0);

        // bad parity is flagged and dropped
        fe_before = fe_count;
        send_frame(`SC_OCT_UP, 1'b1);
        wait_mapper_idle();
        check_value("frame_error pulses", fe_count, fe_before + 1);
        check_params();

        // octave down past 0, then up past 7
        for (i = 0; i < 5; i++) press_octave(1'b0);
        for (i = 0; i < 8; i++) press_octave(1'b1);

        // note on, full attack and amplitude
        send_frame(`SC_NOTE_0, 1'b0);
        wait_mapper_idle();
        check_value("note_active", int'(note_active), 1);
        check_value("note", int'(note), 0);
        ok = 1'b0;
        for (i = 0; i < 2; i++) begin
            wait_tick();
            if (magnitude(sample) == FULL_MAG) ok = 1'b1;
        end
        assert (ok) else fail_now("sample did not reach full level within two ticks");
        // octave 7 flips the square every few ticks
        neg0    = sample < 0;
        flipped = 1'b0;
        for (i = 0; i < 12 && !flipped; i++) begin
            wait_tick();
            check_value("sample magnitude", magnitude(sample), FULL_MAG);
            if ((sample < 0) != neg0) flipped = 1'b1;
        end
        assert (flipped) else fail_now("sample sign did not alternate");

        // break of the held note
        send_frame(`SC_BREAK, 1'b0);
        wait_mapper_idle();
        check_value("note_active", int'(note_active), 1);
        send_frame(`SC_NOTE_0, 1'b0);
        wait_mapper_idle();
        check_value("note_active", int'(note_active), 0);
        ok = 1'b0;
        for (i = 0; i < 3; i++) begin
            wait_tick();
            if (sample == 16'sd0) ok = 1'b1;
        end
        assert (ok) else fail_now("sample did not fall to zero within three ticks");

        // random select and adjust keys
        for (i = 0; i < 40; i++) press_random_key();

        $display("TESTS PASSED");
        $finish;
    end

endmodule
